// File: source/decode_cfg.svh
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

// datapath widths
`define NB                       32
`define NB_REGS                  5
`define NB_OPCODE                6
`define NB_SIZE_TYPE             3

// opcodes
`define RTYPE_OPCODE             6'b000000
`define ADDI_OPCODE              6'b001000
`define SLTI_OPCODE              6'b001010
`define ANDI_OPCODE              6'b001100
`define ORI_OPCODE               6'b001101
`define XORI_OPCODE              6'b001110
`define LUI_OPCODE               6'b001111
`define BEQ_OPCODE               6'b000100
`define BNE_OPCODE               6'b000101
`define J_OPCODE                 6'b000010

// stores
`define SB_OPCODE                6'b101000
`define SH_OPCODE                6'b101001
`define SW_OPCODE                6'b101011

// loads
`define LB_OPCODE                6'b100000
`define LBU_OPCODE               6'b100100
`define LH_OPCODE                6'b100001
`define LHU_OPCODE               6'b100101
`define LW_OPCODE                6'b100011
`define LWU_OPCODE               6'b100111

// memory access size, 0 means no access
`define BYTE_WORD                3'b001
`define HALF_WORD                3'b010
`define COMPLETE_WORD            3'b011

// second alu operand
`define RT_ALU_SRC               1'b0
`define INMEDIATE_ALU_SRC        1'b1

// immediate extension
`define SIGNED_EXTENSION_MODE    2'b00
`define UNSIGNED_EXTENSION_MODE  2'b01

`endif

// File: source/decode_pkg.sv
`include "decode_cfg.svh"

package decode_pkg;

    // one instruction word, seen either as an R/I format or as a J format
    typedef union packed {
        struct packed {
            logic [`NB_OPCODE-1:0] opcode;
            logic [`NB_REGS-1:0]   rs;
            logic [`NB_REGS-1:0]   rt;
            union packed {
                struct packed {
                    logic [`NB_REGS-1:0]   rd;
                    logic [`NB_REGS-1:0]   shamt;
                    logic [`NB_OPCODE-1:0] funct;
                } f;                                 // r-type fields
                logic [15:0] imm16;                  // i-type immediate
            } lo;
        } ri;
        struct packed {
            logic [`NB_OPCODE-1:0]       opcode;
            logic [`NB-`NB_OPCODE-1:0]   target;     // 26-bit jump index
        } j;
    } instr_word_t;

endpackage

// File: source/ctrl_if.sv
`timescale 1ns/1ns
`include "decode_cfg.svh"

interface ctrl_if;

    logic                     alu_src;
    logic                     mem_read;
    logic                     mem_write;
    logic                     mem_to_reg;
    logic                     reg_write;
    logic [`NB_REGS-1:0]      reg_dir_to_write;
    logic                     branch;
    logic                     jump;
    logic                     is_signed;         // loads only
    logic [1:0]               extension_mode;
    logic [`NB_SIZE_TYPE-1:0] word_size;

    modport decoder (
        output alu_src, mem_read, mem_write, mem_to_reg, reg_write,
        output reg_dir_to_write, branch, jump, is_signed,
        output extension_mode, word_size
    );

    modport latch (
        input alu_src, mem_read, mem_write, mem_to_reg, reg_write,
        input reg_dir_to_write, branch, jump, is_signed,
        input extension_mode, word_size
    );

endinterface

// File: source/control_unit.sv
`timescale 1ns/1ns
`include "decode_cfg.svh"

module control_unit (
    input  decode_pkg::instr_word_t i_instruction,
    ctrl_if.decoder                 ctrl
);

    logic [`NB_OPCODE-1:0] opcode;
    logic [`NB_REGS-1:0]   rt;
    logic [`NB_REGS-1:0]   rd;

    assign opcode = i_instruction.ri.opcode;
    assign rt     = i_instruction.ri.rt;
    assign rd     = i_instruction.ri.lo.f.rd;

    always_comb begin
        // defaults, a nop
        ctrl.alu_src          = `RT_ALU_SRC;
        ctrl.mem_read         = 1'b0;
        ctrl.mem_write        = 1'b0;
        ctrl.mem_to_reg       = 1'b0;
        ctrl.reg_write        = 1'b0;
        ctrl.reg_dir_to_write = '0;
        ctrl.branch           = 1'b0;
        ctrl.jump             = 1'b0;
        ctrl.is_signed        = 1'b0;
        ctrl.extension_mode   = `SIGNED_EXTENSION_MODE;
        ctrl.word_size        = '0;                       // no memory access

        case (opcode)
            `RTYPE_OPCODE: begin
                ctrl.reg_write        = 1'b1;
                ctrl.reg_dir_to_write = rd;               // result to rd
            end
            `ADDI_OPCODE, `SLTI_OPCODE: begin
                ctrl.alu_src          = `INMEDIATE_ALU_SRC;
                ctrl.reg_write        = 1'b1;
                ctrl.reg_dir_to_write = rt;
            end
            `ANDI_OPCODE, `ORI_OPCODE, `XORI_OPCODE, `LUI_OPCODE: begin
                ctrl.alu_src          = `INMEDIATE_ALU_SRC;
                ctrl.extension_mode   = `UNSIGNED_EXTENSION_MODE; // logical ops
                ctrl.reg_write        = 1'b1;
                ctrl.reg_dir_to_write = rt;
            end
            `BEQ_OPCODE, `BNE_OPCODE: begin
                ctrl.branch = 1'b1;                       // compare rs, rt
            end
            `J_OPCODE: begin
                ctrl.jump = 1'b1;
            end
            `SB_OPCODE: begin
                ctrl.alu_src   = `INMEDIATE_ALU_SRC;      // base + offset
                ctrl.mem_write = 1'b1;
                ctrl.word_size = `BYTE_WORD;
            end
            `SH_OPCODE: begin
                ctrl.alu_src   = `INMEDIATE_ALU_SRC;
                ctrl.mem_write = 1'b1;
                ctrl.word_size = `HALF_WORD;
            end
            `SW_OPCODE: begin
                ctrl.alu_src   = `INMEDIATE_ALU_SRC;
                ctrl.mem_write = 1'b1;
                ctrl.word_size = `COMPLETE_WORD;
            end
            `LB_OPCODE, `LH_OPCODE, `LW_OPCODE: begin
                ctrl.alu_src          = `INMEDIATE_ALU_SRC;
                ctrl.is_signed        = 1'b1;             // sign-extend loaded data
                ctrl.mem_read         = 1'b1;
                ctrl.mem_to_reg       = 1'b1;             // wb takes memory data
                ctrl.reg_write        = 1'b1;
                ctrl.reg_dir_to_write = rt;
                if (opcode == `LB_OPCODE)
                    ctrl.word_size = `BYTE_WORD;
                else if (opcode == `LH_OPCODE)
                    ctrl.word_size = `HALF_WORD;
                else
                    ctrl.word_size = `COMPLETE_WORD;
            end
            `LBU_OPCODE, `LHU_OPCODE, `LWU_OPCODE: begin
                ctrl.alu_src          = `INMEDIATE_ALU_SRC;
                ctrl.extension_mode   = `UNSIGNED_EXTENSION_MODE;
                ctrl.mem_read         = 1'b1;
                ctrl.mem_to_reg       = 1'b1;
                ctrl.reg_write        = 1'b1;
                ctrl.reg_dir_to_write = rt;
                if (opcode == `LBU_OPCODE)
                    ctrl.word_size = `BYTE_WORD;
                else if (opcode == `LHU_OPCODE)
                    ctrl.word_size = `HALF_WORD;
                else
                    ctrl.word_size = `COMPLETE_WORD;
            end
            default: ;                                    // unknown opcode stays a nop
        endcase
    end

endmodule

// File: source/register_file.sv
`timescale 1ns/1ns
`include "decode_cfg.svh"

module register_file (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic [`NB_REGS-1:0] i_rs_addr,
    input  logic [`NB_REGS-1:0] i_rt_addr,
    input  logic               i_write,
    input  logic [`NB_REGS-1:0] i_write_addr,
    input  logic [`NB-1:0]      i_write_data,
    output logic [`NB-1:0]      o_rs_data,
    output logic [`NB-1:0]      o_rt_data
);

    localparam int N_REGS = 2**`NB_REGS;

    logic [`NB-1:0] regs [N_REGS];

    // one read port, with same-cycle write bypass
    function automatic logic [`NB-1:0] read_port(input logic [`NB_REGS-1:0] addr);
        logic [`NB-1:0] data;
        if (addr == '0)
            data = '0;                                    // r0 is hardwired
        else if (i_write && (i_write_addr == addr))
            data = i_write_data;                          // bypass new value
        else
            data = regs[addr];
        return data;
    endfunction

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < N_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_write && (i_write_addr != '0)) begin
            regs[i_write_addr] <= i_write_data;           // r0 writes dropped
        end
    end

    always_comb begin
        o_rs_data = read_port(i_rs_addr);
        o_rt_data = read_port(i_rt_addr);
    end

endmodule

// File: source/id_ex_latch.sv
`timescale 1ns/1ns
`include "decode_cfg.svh"

module id_ex_latch (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic                     i_stall,
    input  logic                     i_flush,
    ctrl_if.latch                    ctrl,
    input  decode_pkg::instr_word_t  i_instruction,
    input  logic [`NB-1:0]           i_pc_plus4,
    input  logic [`NB-1:0]           i_rs_data,
    input  logic [`NB-1:0]           i_rt_data,
    output logic                     o_alu_src,
    output logic                     o_mem_read,
    output logic                     o_mem_write,
    output logic                     o_mem_to_reg,
    output logic                     o_reg_write,
    output logic [`NB_REGS-1:0]      o_reg_dir_to_write,
    output logic                     o_branch,
    output logic                     o_jump,
    output logic                     o_signed,
    output logic [1:0]               o_extension_mode,
    output logic [`NB_SIZE_TYPE-1:0] o_word_size,
    output logic [`NB-1:0]           o_rs_data,
    output logic [`NB-1:0]           o_rt_data,
    output logic [`NB-1:0]           o_imm_ext,
    output logic [`NB-1:0]           o_branch_target,
    output logic [`NB-1:0]           o_jump_target,
    output logic [`NB_OPCODE-1:0]    o_funct
);

    logic [15:0]    imm16;
    logic [`NB-1:0] imm_sext;
    logic [`NB-1:0] imm_ext;
    logic [`NB-1:0] branch_target;
    logic [`NB-1:0] jump_target;

    assign imm16    = i_instruction.ri.lo.imm16;
    assign imm_sext = {{(`NB-16){imm16[15]}}, imm16};
    assign imm_ext  = (ctrl.extension_mode == `UNSIGNED_EXTENSION_MODE) ?
                      {{(`NB-16){1'b0}}, imm16} : imm_sext;

    // branch offset is always signed, whatever the mode
    assign branch_target = i_pc_plus4 + {imm_sext[`NB-3:0], 2'b00};
    assign jump_target   = {i_pc_plus4[`NB-1:`NB-4], i_instruction.j.target, 2'b00};

    always_ff @(posedge i_clk) begin
        if (!i_rst_n || (!i_stall && i_flush)) begin
            o_alu_src          <= 1'b0;                   // bubble
            o_mem_read         <= 1'b0;
            o_mem_write        <= 1'b0;
            o_mem_to_reg       <= 1'b0;
            o_reg_write        <= 1'b0;
            o_reg_dir_to_write <= '0;
            o_branch           <= 1'b0;
            o_jump             <= 1'b0;
            o_signed           <= 1'b0;
            o_extension_mode   <= '0;
            o_word_size        <= '0;
        end else if (!i_stall) begin
            o_alu_src          <= ctrl.alu_src;
            o_mem_read         <= ctrl.mem_read;
            o_mem_write        <= ctrl.mem_write;
            o_mem_to_reg       <= ctrl.mem_to_reg;
            o_reg_write        <= ctrl.reg_write;
            o_reg_dir_to_write <= ctrl.reg_dir_to_write;
            o_branch           <= ctrl.branch;
            o_jump             <= ctrl.jump;
            o_signed           <= ctrl.is_signed;
            o_extension_mode   <= ctrl.extension_mode;
            o_word_size        <= ctrl.word_size;
        end
    end

    // data side ignores flush
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_rs_data       <= '0;
            o_rt_data       <= '0;
            o_imm_ext       <= '0;
            o_branch_target <= '0;
            o_jump_target   <= '0;
            o_funct         <= '0;
        end else if (!i_stall) begin
            o_rs_data       <= i_rs_data;
            o_rt_data       <= i_rt_data;
            o_imm_ext       <= imm_ext;
            o_branch_target <= branch_target;
            o_jump_target   <= jump_target;
            o_funct         <= i_instruction.ri.lo.f.funct;
        end
    end

endmodule

// File: source/decode_stage.sv
`timescale 1ns/1ns
`include "decode_cfg.svh"

module decode_stage (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic [`NB-1:0]           i_instruction,
    input  logic [`NB-1:0]           i_pc_plus4,
    input  logic                     i_stall,
    input  logic                     i_flush,
    input  logic                     i_wb_write,
    input  logic [`NB_REGS-1:0]      i_wb_addr,
    input  logic [`NB-1:0]           i_wb_data,
    output logic                     o_alu_src,
    output logic                     o_mem_read,
    output logic                     o_mem_write,
    output logic                     o_mem_to_reg,
    output logic                     o_reg_write,
    output logic [`NB_REGS-1:0]      o_reg_dir_to_write,
    output logic                     o_branch,
    output logic                     o_jump,
    output logic                     o_signed,
    output logic [1:0]               o_extension_mode,
    output logic [`NB_SIZE_TYPE-1:0] o_word_size,
    output logic [`NB-1:0]           o_rs_data,
    output logic [`NB-1:0]           o_rt_data,
    output logic [`NB-1:0]           o_imm_ext,
    output logic [`NB-1:0]           o_branch_target,
    output logic [`NB-1:0]           o_jump_target,
    output logic [`NB_OPCODE-1:0]    o_funct
);

    decode_pkg::instr_word_t instr_word;
    logic [`NB-1:0]          rs_data;
    logic [`NB-1:0]          rt_data;

    assign instr_word = i_instruction;

    ctrl_if ctrl ();

    control_unit u_control_unit (
        .i_instruction (instr_word),
        .ctrl          (ctrl.decoder)
    );

    register_file u_register_file (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_rs_addr    (instr_word.ri.rs),
        .i_rt_addr    (instr_word.ri.rt),
        .i_write      (i_wb_write),                      // write-back port
        .i_write_addr (i_wb_addr),
        .i_write_data (i_wb_data),
        .o_rs_data    (rs_data),
        .o_rt_data    (rt_data)
    );

    id_ex_latch u_id_ex_latch (
        .i_clk              (i_clk),
        .i_rst_n            (i_rst_n),
        .i_stall            (i_stall),
        .i_flush            (i_flush),
        .ctrl               (ctrl.latch),
        .i_instruction      (instr_word),
        .i_pc_plus4         (i_pc_plus4),
        .i_rs_data          (rs_data),
        .i_rt_data          (rt_data),
        .o_alu_src          (o_alu_src),
        .o_mem_read         (o_mem_read),
        .o_mem_write        (o_mem_write),
        .o_mem_to_reg       (o_mem_to_reg),
        .o_reg_write        (o_reg_write),
        .o_reg_dir_to_write (o_reg_dir_to_write),
        .o_branch           (o_branch),
        .o_jump             (o_jump),
        .o_signed           (o_signed),
        .o_extension_mode   (o_extension_mode),
        .o_word_size        (o_word_size),
        .o_rs_data          (o_rs_data),
        .o_rt_data          (o_rt_data),
        .o_imm_ext          (o_imm_ext),
        .o_branch_target    (o_branch_target),
        .o_jump_target      (o_jump_target),
        .o_funct            (o_funct)
    );

endmodule

// File: dv/decode_stage_asserts.sv
`timescale 1ns/1ns
`include "decode_cfg.svh"

module decode_stage_asserts (
    input logic           i_clk,
    input logic           i_rst_n,
    input logic           i_stall,
    input logic           i_flush,
    input logic           i_mem_read,
    input logic           i_mem_write,
    input logic           i_reg_write,
    input logic           i_branch,
    input logic           i_jump,
    input logic [`NB-1:0] i_rs_data,
    input logic [`NB-1:0] i_imm_ext
);

    // a memory op is either a load or a store
    mem_exclusive: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) !(i_mem_read && i_mem_write)
    ) else $error("mem_read and mem_write high together");

    stall_holds: assert property (
        @(posedge i_clk) (i_rst_n && i_stall) |=>
            $stable({i_mem_read, i_mem_write, i_reg_write, i_branch, i_jump,
                     i_rs_data, i_imm_ext})
    ) else $error("latch outputs changed under stall");

    flush_bubble: assert property (
        @(posedge i_clk) (i_rst_n && i_flush && !i_stall) |=>
            !(i_reg_write || i_mem_write || i_branch || i_jump)
    ) else $error("controls not cleared after flush");

endmodule

// File: dv/decode_stage_tb.sv
`timescale 1ns/1ns
`include "decode_cfg.svh"

module decode_stage_tb;

    localparam int N_DECODE     = 200;
    localparam int N_REGFILE    = 300;
    localparam int N_IMM        = 200;
    localparam int N_STALL      = 300;
    localparam int TOTAL_CYCLES = 5 + N_DECODE + N_REGFILE + N_IMM + N_STALL;

    logic                     i_clk = 1'b0;
    logic                     i_rst_n;
    logic [`NB-1:0]           i_instruction;
    logic [`NB-1:0]           i_pc_plus4;
    logic                     i_stall;
    logic                     i_flush;
    logic                     i_wb_write;
    logic [`NB_REGS-1:0]      i_wb_addr;
    logic [`NB-1:0]           i_wb_data;
    logic                     o_alu_src;
    logic                     o_mem_read;
    logic                     o_mem_write;
    logic                     o_mem_to_reg;
    logic                     o_reg_write;
    logic [`NB_REGS-1:0]      o_reg_dir_to_write;
    logic                     o_branch;
    logic                     o_jump;
    logic                     o_signed;
    logic [1:0]               o_extension_mode;
    logic [`NB_SIZE_TYPE-1:0] o_word_size;
    logic [`NB-1:0]           o_rs_data;
    logic [`NB-1:0]           o_rt_data;
    logic [`NB-1:0]           o_imm_ext;
    logic [`NB-1:0]           o_branch_target;
    logic [`NB-1:0]           o_jump_target;
    logic [`NB_OPCODE-1:0]    o_funct;

    // table entry: alu_src mem_read mem_write mem_to_reg reg_write | dest | br jmp sgn | ext | size
    logic [14:0]  dec_table [64];
    logic [5:0]   op_list [$];
    logic [31:0]  shadow [32];                            // model register file
    logic [17:0]  exp_ctrl;
    logic [17:0]  act_ctrl;
    logic [31:0]  exp_rs, exp_rt, exp_imm, exp_bt, exp_jt;
    logic [5:0]   exp_funct;
    int           seed = 82;
    int           errors = 0;
    int           checks = 0;
    int           tests_run = 0;
    int           tests_failed = 0;

    assign act_ctrl = {o_alu_src, o_mem_read, o_mem_write, o_mem_to_reg, o_reg_write,
                       o_reg_dir_to_write, o_branch, o_jump, o_signed, o_extension_mode,
                       o_word_size};

    decode_stage uut (.*);

    bind id_ex_latch decode_stage_asserts u_asserts (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_stall     (i_stall),
        .i_flush     (i_flush),
        .i_mem_read  (o_mem_read),
        .i_mem_write (o_mem_write),
        .i_reg_write (o_reg_write),
        .i_branch    (o_branch),
        .i_jump      (o_jump),
        .i_rs_data   (o_rs_data),
        .i_imm_ext   (o_imm_ext)
    );

    always #20 i_clk = ~i_clk;

    task automatic add_op(input logic [5:0] op, input logic [14:0] entry);
        dec_table[op] = entry;
        op_list.push_back(op);
    endtask

    task automatic build_table;
        for (int i = 0; i < 64; i++) dec_table[i] = '0;    // unknown opcodes, all zero
        add_op(`RTYPE_OPCODE, {5'b00001, 2'd1, 3'b000, `SIGNED_EXTENSION_MODE, 3'd0});
        add_op(`ADDI_OPCODE,  {5'b10001, 2'd2, 3'b000, `SIGNED_EXTENSION_MODE, 3'd0});
        add_op(`SLTI_OPCODE,  {5'b10001, 2'd2, 3'b000, `SIGNED_EXTENSION_MODE, 3'd0});
        add_op(`ANDI_OPCODE,  {5'b10001, 2'd2, 3'b000, `UNSIGNED_EXTENSION_MODE, 3'd0});
        add_op(`ORI_OPCODE,   {5'b10001, 2'd2, 3'b000, `UNSIGNED_EXTENSION_MODE, 3'd0});
        add_op(`XORI_OPCODE,  {5'b10001, 2'd2, 3'b000, `UNSIGNED_EXTENSION_MODE, 3'd0});
        add_op(`LUI_OPCODE,   {5'b10001, 2'd2, 3'b000, `UNSIGNED_EXTENSION_MODE, 3'd0});
        add_op(`BEQ_OPCODE,   {5'b00000, 2'd0, 3'b100, `SIGNED_EXTENSION_MODE, 3'd0});
        add_op(`BNE_OPCODE,   {5'b00000, 2'd0, 3'b100, `SIGNED_EXTENSION_MODE, 3'd0});
        add_op(`J_OPCODE,     {5'b00000, 2'd0, 3'b010, `SIGNED_EXTENSION_MODE, 3'd0});
        add_op(`SB_OPCODE,    {5'b10100, 2'd0, 3'b000, `SIGNED_EXTENSION_MODE, `BYTE_WORD});
        add_op(`SH_OPCODE,    {5'b10100, 2'd0, 3'b000, `SIGNED_EXTENSION_MODE, `HALF_WORD});
        add_op(`SW_OPCODE,    {5'b10100, 2'd0, 3'b000, `SIGNED_EXTENSION_MODE, `COMPLETE_WORD});
        add_op(`LB_OPCODE,    {5'b11011, 2'd2, 3'b001, `SIGNED_EXTENSION_MODE, `BYTE_WORD});
        add_op(`LH_OPCODE,    {5'b11011, 2'd2, 3'b001, `SIGNED_EXTENSION_MODE, `HALF_WORD});
        add_op(`LW_OPCODE,    {5'b11011, 2'd2, 3'b001, `SIGNED_EXTENSION_MODE, `COMPLETE_WORD});
        add_op(`LBU_OPCODE,   {5'b11011, 2'd2, 3'b000, `UNSIGNED_EXTENSION_MODE, `BYTE_WORD});
        add_op(`LHU_OPCODE,   {5'b11011, 2'd2, 3'b000, `UNSIGNED_EXTENSION_MODE, `HALF_WORD});
        add_op(`LWU_OPCODE,   {5'b11011, 2'd2, 3'b000, `UNSIGNED_EXTENSION_MODE, `COMPLETE_WORD});
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    function automatic logic [31:0] read_ref(input logic [4:0] addr);
        if (addr == 5'd0) return 32'd0;
        if (i_wb_write && (i_wb_addr == addr)) return i_wb_data;    // same-cycle write
        return shadow[addr];
    endfunction

    // expected latch contents after the next rising edge
    task automatic predict;
        logic [14:0] e;
        logic [4:0]  dest;
        logic [31:0] sext;
        e    = dec_table[i_instruction[31:26]];
        sext = {{16{i_instruction[15]}}, i_instruction[15:0]};
        if (!i_stall) begin
            dest = (e[9:8] == 2'd1) ? i_instruction[15:11] :
                   (e[9:8] == 2'd2) ? i_instruction[20:16] : 5'd0;
            exp_ctrl  = i_flush ? '0 : {e[14:10], dest, e[7:0]};
            exp_rs    = read_ref(i_instruction[25:21]);
            exp_rt    = read_ref(i_instruction[20:16]);
            exp_imm   = (e[4:3] == `UNSIGNED_EXTENSION_MODE) ? {16'h0, i_instruction[15:0]} : sext;
            exp_bt    = i_pc_plus4 + (sext << 2);
            exp_jt    = {i_pc_plus4[31:28], i_instruction[25:0], 2'b00};
            exp_funct = i_instruction[5:0];
        end
        if (i_wb_write && (i_wb_addr != 5'd0)) shadow[i_wb_addr] = i_wb_data;
    endtask

    task automatic compare_outputs(input string name);
        check_value({name, " controls"}, 32'(exp_ctrl), 32'(act_ctrl));
        check_value({name, " rs_data"}, exp_rs, o_rs_data);
        check_value({name, " rt_data"}, exp_rt, o_rt_data);
        check_value({name, " imm_ext"}, exp_imm, o_imm_ext);
        check_value({name, " branch_target"}, exp_bt, o_branch_target);
        check_value({name, " jump_target"}, exp_jt, o_jump_target);
        check_value({name, " funct"}, 32'(exp_funct), 32'(o_funct));
    endtask

    // called on a falling edge, returns on the next one
    task automatic cycle(input string name, input bit wb_on, input bit sf_on);
        logic [31:0] r;
        int          idx;
        r   = $random(seed);
        idx = int'(r[31:27]) % op_list.size();
        i_instruction[31:26] = r[2] ? op_list[idx] : r[31:26];  // otherwise mostly invalid
        r = $random(seed);
        i_instruction[25:0] = r[25:0];
        r = $random(seed);
        i_pc_plus4 = {r[31:2], 2'b00};
        r = $random(seed);
        i_wb_write = wb_on & r[0];
        i_wb_addr  = (r[2:1] == 2'd0) ? i_instruction[25:21] :
                     (r[2:1] == 2'd1) ? i_instruction[20:16] :
                     (r[4:3] == 2'd0) ? 5'd0 : r[12:8];
        i_wb_data  = $random(seed);
        i_stall    = sf_on & r[16] & r[17];
        i_flush    = sf_on & r[18] & r[19];
        predict();
        @(posedge i_clk);
        @(negedge i_clk);
        compare_outputs(name);
    endtask

    task automatic report_test(input string name, input int errors_before, input int n);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: %0d cycles, ok", name, n);
        end else begin
            tests_failed++;
            $display("test %s: %0d cycles, %0d errors", name, n, errors - errors_before);
        end
    endtask

    task automatic run_test(input string name, input int n, input bit wb_on, input bit sf_on);
        int errors_before;
        errors_before = errors;
        repeat (n) cycle(name, wb_on, sf_on);
        report_test(name, errors_before, n);
    endtask

    initial begin
        i_rst_n       = 1'b0;
        i_instruction = 32'h8ca6_8004;                    // lw, negative offset, funct bits set
        i_pc_plus4    = 32'h0040_1000;
        i_stall       = 1'b0;
        i_flush       = 1'b0;
        i_wb_write    = 1'b0;
        i_wb_addr     = '0;
        i_wb_data     = '0;
        {exp_ctrl, exp_rs, exp_rt, exp_imm, exp_bt, exp_jt, exp_funct} = '0;
        for (int i = 0; i < 32; i++) shadow[i] = '0;
        build_table();
        repeat (4) @(posedge i_clk);
        @(negedge i_clk);
        compare_outputs("reset");
        report_test("reset", 0, 4);
        i_rst_n = 1'b1;
        run_test("decode", N_DECODE, 1'b0, 1'b0);
        run_test("regfile", N_REGFILE, 1'b1, 1'b0);
        run_test("imm_targets", N_IMM, 1'b1, 1'b0);
        run_test("stall_flush", N_STALL, 1'b1, 1'b1);
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        #(TOTAL_CYCLES * 40 + 2000);
        $display("timeout: the tests did not finish in the expected time");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: decode_stage.f
+incdir+source
source/decode_pkg.sv
source/ctrl_if.sv
source/control_unit.sv
source/register_file.sv
source/id_ex_latch.sv
source/decode_stage.sv
dv/decode_stage_asserts.sv
dv/decode_stage_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = decode_stage_tb
FILELIST = decode_stage.f
LOG      = sim.log

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); exit $$rc
	! grep -qF "*** TEST FAILED ***" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean
